// ==== sim/tq_itq_tests.txt ====
// qp, level[0..15] as 16-bit two's complement, pred[0..15], expected pixel[0..15]
// all values hex, blocks in raster order, one block per line
00 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 ff 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 ff
33 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 ff 01 7f 80 12 34 56 78 9a bc de f0 0f 1e 2d 3c ff 01 7f 80 12 34 56 78 9a bc de f0 0f 1e 2d 3c
00 0040 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 f5 1a 2a 3a 4a 5a 6a 7a 8a 9a aa ba ca da ea fa ff
0c 0005 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76
1c fffd 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0c 0d 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 ff 00 01 14 24 34 44 54 64 74 84 94 a4 b4 c4 d4 f3
03 0007 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 82 82 82 82 82 82 82 82 82 82 82 82 82 82 82 82
33 0064 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00 01 10 20 40 60 80 a0 c0 e0 f0 fe ff 7f 3f 1f ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
33 ff9c 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 ff fe f0 e0 c0 a0 80 60 40 20 10 02 01 00 7f 3f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1e 0008 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 fa d7 d8 00 ff 80 c0 d6 10 20 30 40 50 60 70 e0 ff ff ff 28 ff a8 e8 fe 38 48 58 68 78 88 98 ff
1e fff8 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 05 28 27 ff 00 80 29 c0 10 20 30 40 50 60 70 e0 00 00 00 d7 00 58 01 98 00 00 08 18 28 38 48 b8
12 0004 0002 0000 0000 0001 ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 64 6e 78 82 64 6e 78 82 64 6e 78 82 64 6e 78 82 6c 75 7e 87 6c 75 7d 86 6c 74 7a 82 6d 74 79 80
05 000a 0000 0000 0002 0000 0000 0000 0000 0000 0000 fffd 0000 0004 0000 0000 0001 32 32 32 32 32 32 32 32 32 32 32 32 32 32 32 32 35 35 37 34 34 32 33 34 38 34 37 37 34 34 35 33
21 fffe 0003 0000 0000 0000 0000 ffff 0001 0000 0002 0000 0000 0000 0000 0000 0000 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 9c 86 70 36 79 75 78 62 7d 78 63 70 a2 8b 47 54
2c 0000 0000 0000 0000 0000 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 8c 78 50 3c 78 6e 5a 50 50 5a 6e 78 3c 50 78 8c

// ==== vlog.f ====
source/tq_pkg.sv
source/tq_idct4h.sv
source/tq_idct4v.sv
source/tq_idct_4x4.sv
source/tq_dequant_4x4.sv
source/tq_recon_4x4.sv
source/tq_itq_top.sv
sim/tq_itq_tb.sv

// ==== Bender.yml ====
package:
  name: tq_itq

sources:
  - source/tq_pkg.sv
  - source/tq_idct4h.sv
  - source/tq_idct4v.sv
  - source/tq_idct_4x4.sv
  - source/tq_dequant_4x4.sv
  - source/tq_recon_4x4.sv
  - source/tq_itq_top.sv
  - target: test
    files:
      - sim/tq_itq_tb.sv

// ==== sim/tq_itq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tq_itq_tb import tq_pkg::*; ();

    // one record is qp, 16 levels, 16 prediction pixels, 16 expected pixels
    localparam int REC_W     = 49;
    localparam int MAX_TESTS = 64;
    localparam int LVL_OFS   = 1;
    localparam int PRED_OFS  = 17;
    localparam int EXP_OFS   = 33;

    logic     clk_i;
    logic     arst_n_i;
    logic     req_valid_i;
    logic     req_ready_o;
    itq_req_t req_i;
    logic     pix_valid_o;
    logic     pix_ready_i;
    pix_blk_t pix_o;

    logic [15:0] vec_mem [0:MAX_TESTS*REC_W-1];

    int unsigned rng_state;
    int          ntests;
    int          cycle_limit;
    int          cycle_cnt;
    int          send_idx;
    int          out_count;
    int          accept_cyc;
    int          valid_cyc;
    int          errors;
    int          checks;
    bit          timed_out;
    bit          held_valid;
    pix_blk_t    held_blk;

    tq_itq_top dut0 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .pix_valid_o (pix_valid_o),
        .pix_ready_i (pix_ready_i),
        .pix_o       (pix_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // about one cycle in four is a stall, taken from the upper bits
    function automatic bit stall_roll();
        rng_state = lcg_next(rng_state);
        return rng_state[31:30] == 2'b00;
    endfunction

    function automatic itq_req_t req_from_vec(input int idx);
        itq_req_t r;
        int       base;
        base   = idx * REC_W;
        r.qp   = vec_mem[base][QP_W-1:0];
        for (int i = 0; i < 16; i++) begin
            r.level[i] = vec_mem[base + LVL_OFS + i][COEF_W-1:0];
            r.pred[i]  = vec_mem[base + PRED_OFS + i][PIX_W-1:0];
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic load_tests();
        $readmemh("sim/tq_itq_tests.txt", vec_mem);
        ntests = 0;
        while (ntests < MAX_TESTS && !$isunknown(vec_mem[ntests*REC_W + REC_W - 1])) begin
            ntests++;
        end
        cycle_limit = 50 * ntests + 100;
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // driver, monitor and cycle counter share one process and one generator
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            if (cycle_cnt >= cycle_limit) begin
                timed_out = 1'b1;
            end

            if (pix_valid_o && valid_cyc < 0) begin
                valid_cyc = cycle_cnt;
                check_value("first output latency", valid_cyc - accept_cyc, 2);
            end
            // a stalled block must stay put until it is taken
            if (held_valid && !pix_valid_o) begin
                errors++;
                $display("error at t=%0t: pix_valid_o dropped while the block was stalled",
                         $time);
            end else if (held_valid) begin
                for (int i = 0; i < 16; i++) begin
                    check_value($sformatf("pix_o[%0d]", i), pix_o[i], held_blk[i]);
                end
            end
            held_valid = 1'b0;
            if (pix_valid_o && pix_ready_i) begin
                if (out_count >= ntests) begin
                    errors++;
                    $display("error at t=%0t: output block beyond the last test", $time);
                end else begin
                    for (int i = 0; i < 16; i++) begin
                        check_value($sformatf("pix_o[%0d]", i), pix_o[i],
                                    vec_mem[out_count*REC_W + EXP_OFS + i][PIX_W-1:0]);
                    end
                end
                out_count++;
            end else if (pix_valid_o) begin
                held_valid = 1'b1;
                held_blk   = pix_o;
            end

            // request side, hold the request while it waits for ready
            if (req_valid_i && req_ready_o) begin
                if (accept_cyc < 0) begin
                    accept_cyc = cycle_cnt;
                end
                send_idx++;
            end
            if (!req_valid_i || req_ready_o) begin
                if (send_idx < ntests && (send_idx == 0 || !stall_roll())) begin
                    req_i       <= req_from_vec(send_idx);
                    req_valid_i <= 1'b1;
                end else begin
                    req_valid_i <= 1'b0;
                end
            end

            // sink stalls only start once the first block was seen
            if (valid_cyc < 0) begin
                pix_ready_i <= 1'b1;
            end else begin
                pix_ready_i <= !stall_roll();
            end

            cycle_cnt++;
        end
    end

    initial begin
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        pix_ready_i = 1'b1;
        rng_state   = 32'd10361;
        cycle_cnt   = 0;
        send_idx    = 0;
        out_count   = 0;
        accept_cyc  = -1;
        valid_cyc   = -1;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        held_valid  = 1'b0;
        load_tests();

        if (ntests == 0) begin
            errors++;
            $display("error: no test vectors could be read from sim/tq_itq_tests.txt");
        end else begin
            repeat (3) @(posedge clk_i);
            arst_n_i <= 1'b1;
            @(negedge clk_i);
            check_value("pix_valid_o", pix_valid_o, 0);
            check_value("req_ready_o", req_ready_o, 1);

            while (out_count < ntests && !timed_out) begin
                @(posedge clk_i);
            end
            if (timed_out) begin
                errors++;
                $display("timeout: only %0d of %0d blocks came out after %0d cycles",
                         out_count, ntests, cycle_cnt);
            end else begin
                // a few more cycles to catch any stray block
                repeat (5) @(posedge clk_i);
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== source/tq_itq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tq_itq_top import tq_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  itq_req_t req_i,

    output logic     pix_valid_o,
    input  logic     pix_ready_i,
    output pix_blk_t pix_o
);

    logic      deq_valid;
    logic      deq_ready;
    deq_blk_t  deq_blk;
    coef_blk_t resid;

    // stage 1, dequantize and register
    tq_dequant_4x4 u_dequant (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .deq_valid_o (deq_valid),
        .deq_ready_i (deq_ready),
        .deq_o       (deq_blk)
    );

    // combinational inverse transform between the stages
    tq_idct_4x4 u_idct (
        .coef_i  (deq_blk.coef),
        .resid_o (resid)
    );

    // stage 2, reconstruct and register
    tq_recon_4x4 u_recon (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .deq_valid_i (deq_valid),
        .deq_ready_o (deq_ready),
        .resid_i     (resid),
        .pred_i      (deq_blk.pred),
        .pix_valid_o (pix_valid_o),
        .pix_ready_i (pix_ready_i),
        .pix_o       (pix_o)
    );

endmodule

`default_nettype wire

// ==== source/tq_recon_4x4.sv ====
`timescale 1ns/1ps
`default_nettype none

module tq_recon_4x4 import tq_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  logic      deq_valid_i,
    output logic      deq_ready_o,
    input  coef_blk_t resid_i,
    input  pix_blk_t  pred_i,

    output logic      pix_valid_o,
    input  logic      pix_ready_i,
    output pix_blk_t  pix_o
);

    pix_blk_t recon;
    logic     valid_q;
    pix_blk_t pix_q;

    // residual plus prediction, clipped to the pixel range
    always_comb begin
        logic signed [COEF_W:0] sum;
        for (int i = 0; i < 16; i++) begin
            sum = resid_i[i] + $signed({1'b0, pred_i[i]});
            if (sum < 0) begin
                recon[i] = '0;
            end else if (sum > PIX_MAX) begin
                recon[i] = pix_t'(PIX_MAX);
            end else begin
                recon[i] = sum[PIX_W-1:0];
            end
        end
    end

    assign deq_ready_o = !valid_q || pix_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (deq_ready_o) begin
            valid_q <= deq_valid_i;
        end
    end

    // block is held unchanged while the sink stalls
    always_ff @(posedge clk_i) begin
        if (deq_valid_i && deq_ready_o) begin
            pix_q <= recon;
        end
    end

    assign pix_valid_o = valid_q;
    assign pix_o       = pix_q;

endmodule

`default_nettype wire

// ==== source/tq_dequant_4x4.sv ====
`timescale 1ns/1ps
`default_nettype none

module tq_dequant_4x4 import tq_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  itq_req_t req_i,

    output logic     deq_valid_o,
    input  logic     deq_ready_i,
    output deq_blk_t deq_o
);

    logic [2:0] qp_mod;
    logic [3:0] qp_div;
    coef_blk_t  deq_coef;
    logic       valid_q;
    deq_blk_t   blk_q;

    // position class from the raster index
    function automatic int pos_class(input int idx);
        int row;
        int col;
        row = idx / 4;
        col = idx % 4;
        if ((row % 2 == 0) && (col % 2 == 0)) begin
            return 0;
        end else if ((row % 2 == 1) && (col % 2 == 1)) begin
            return 1;
        end
        return 2;
    endfunction

    // level * scale << shift, saturated to the coefficient range
    function automatic coef_t scale_level(
        input coef_t      level,
        input int         scale,
        input logic [3:0] shift
    );
        logic signed [31:0] prod;
        prod = 32'(level) * scale;
        prod = prod <<< shift;
        if (prod > COEF_MAX) begin
            return coef_t'(COEF_MAX);
        end else if (prod < COEF_MIN) begin
            return coef_t'(COEF_MIN);
        end
        return prod[COEF_W-1:0];
    endfunction

    assign qp_mod = 3'(req_i.qp % 6);
    assign qp_div = 4'(req_i.qp / 6);

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            deq_coef[i] = scale_level(req_i.level[i], LEVEL_SCALE[qp_mod][pos_class(i)], qp_div);
        end
    end

    // stage accepts when empty or when its block leaves this cycle
    assign req_ready_o = !valid_q || deq_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    // payload only
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            blk_q.coef <= deq_coef;
            blk_q.pred <= req_i.pred;
        end
    end

    assign deq_valid_o = valid_q;
    assign deq_o       = blk_q;

endmodule

`default_nettype wire

// ==== source/tq_idct_4x4.sv ====
`timescale 1ns/1ps
`default_nettype none

module tq_idct_4x4 import tq_pkg::*; (
    input  coef_blk_t coef_i,
    output coef_blk_t resid_o
);

    localparam int ROW_W = COEF_W + 2;

    // row pass results, tmp[row][col]
    logic signed [ROW_W-1:0] tmp [4][4];

    // horizontal pass, one butterfly per row
    for (genvar r = 0; r < 4; r++) begin : g_row
        tq_idct4h u_idct_h (
            .s0_i (coef_i[r*4+0]),
            .s1_i (coef_i[r*4+1]),
            .s2_i (coef_i[r*4+2]),
            .s3_i (coef_i[r*4+3]),
            .d0_o (tmp[r][0]),
            .d1_o (tmp[r][1]),
            .d2_o (tmp[r][2]),
            .d3_o (tmp[r][3])
        );
    end

    // vertical pass over the transposed intermediate
    // column c result k lands at raster position k*4+c
    for (genvar c = 0; c < 4; c++) begin : g_col
        tq_idct4v u_idct_v (
            .s0_i (tmp[0][c]),
            .s1_i (tmp[1][c]),
            .s2_i (tmp[2][c]),
            .s3_i (tmp[3][c]),
            .d0_o (resid_o[0*4+c]),
            .d1_o (resid_o[1*4+c]),
            .d2_o (resid_o[2*4+c]),
            .d3_o (resid_o[3*4+c])
        );
    end

endmodule

`default_nettype wire

// ==== source/tq_idct4v.sv ====
`timescale 1ns/1ps
`default_nettype none

module tq_idct4v import tq_pkg::*; (
    input  logic signed [COEF_W+1:0] s0_i,
    input  logic signed [COEF_W+1:0] s1_i,
    input  logic signed [COEF_W+1:0] s2_i,
    input  logic signed [COEF_W+1:0] s3_i,
    output logic signed [COEF_W-1:0] d0_o,
    output logic signed [COEF_W-1:0] d1_o,
    output logic signed [COEF_W-1:0] d2_o,
    output logic signed [COEF_W-1:0] d3_o
);

    localparam int ROW_W = COEF_W + 2;
    // two more bits of headroom for the column sums
    localparam int ACC_W = ROW_W + 2;

    logic signed [ACC_W-1:0] s0_x, s1_x, s2_x, s3_x;
    logic signed [ACC_W-1:0] e0, e1, o0, o1;
    logic signed [ACC_W-1:0] r0, r1, r2, r3;
    logic signed [ACC_W-1:0] q0, q1, q2, q3;

    assign s0_x = s0_i;
    assign s1_x = s1_i;
    assign s2_x = s2_i;
    assign s3_x = s3_i;

    assign e0 = s0_x + s2_x;
    assign e1 = s0_x - s2_x;
    assign o0 = s1_x + (s3_x >>> 1);
    assign o1 = (s1_x >>> 1) - s3_x;

    // round to nearest before dropping 6 fraction bits
    assign r0 = e0 + o0 + ACC_W'(32);
    assign r1 = e1 + o1 + ACC_W'(32);
    assign r2 = e1 - o1 + ACC_W'(32);
    assign r3 = e0 - o0 + ACC_W'(32);

    assign q0 = r0 >>> 6;
    assign q1 = r1 >>> 6;
    assign q2 = r2 >>> 6;
    assign q3 = r3 >>> 6;

    assign d0_o = q0[COEF_W-1:0];
    assign d1_o = q1[COEF_W-1:0];
    assign d2_o = q2[COEF_W-1:0];
    assign d3_o = q3[COEF_W-1:0];

endmodule

`default_nettype wire

// ==== source/tq_idct4h.sv ====
`timescale 1ns/1ps
`default_nettype none

module tq_idct4h import tq_pkg::*; (
    input  logic signed [COEF_W-1:0] s0_i,
    input  logic signed [COEF_W-1:0] s1_i,
    input  logic signed [COEF_W-1:0] s2_i,
    input  logic signed [COEF_W-1:0] s3_i,
    output logic signed [COEF_W+1:0] d0_o,
    output logic signed [COEF_W+1:0] d1_o,
    output logic signed [COEF_W+1:0] d2_o,
    output logic signed [COEF_W+1:0] d3_o
);

    localparam int ROW_W = COEF_W + 2;

    logic signed [ROW_W-1:0] s0_x, s1_x, s2_x, s3_x;
    logic signed [ROW_W-1:0] e0, e1, o0, o1;

    // sign extend before the adds
    assign s0_x = s0_i;
    assign s1_x = s1_i;
    assign s2_x = s2_i;
    assign s3_x = s3_i;

    // even part
    assign e0 = s0_x + s2_x;
    assign e1 = s0_x - s2_x;
    // odd part uses halved s1 and s3
    assign o0 = s1_x + (s3_x >>> 1);
    assign o1 = (s1_x >>> 1) - s3_x;

    assign d0_o = e0 + o0;
    assign d1_o = e1 + o1;
    assign d2_o = e1 - o1;
    assign d3_o = e0 - o0;

endmodule

`default_nettype wire

// ==== source/tq_pkg.sv ====
`default_nettype none

package tq_pkg;

    // coefficient width for levels, dequantized values and residuals
    localparam int COEF_W = 15;
    // reconstructed pixel width
    localparam int PIX_W = 8;
    // quantizer parameter width, legal range 0..51
    localparam int QP_W = 6;

    // saturation bounds for a signed coefficient
    localparam int COEF_MAX = (2 ** (COEF_W - 1)) - 1;
    localparam int COEF_MIN = -(2 ** (COEF_W - 1));

    // largest pixel value
    localparam int PIX_MAX = (2 ** PIX_W) - 1;

    // dequantization factors, indexed by qp % 6 and position class
    // class 0: row and col even, class 1: row and col odd, class 2: mixed
    localparam int LEVEL_SCALE [6][3] = '{
        '{10, 16, 13},
        '{11, 18, 14},
        '{13, 20, 16},
        '{14, 23, 18},
        '{16, 25, 20},
        '{18, 29, 23}
    };

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [QP_W-1:0] qp_t;

    // 4x4 blocks in raster order, element index is row * 4 + col
    typedef coef_t [15:0] coef_blk_t;
    typedef pix_t [15:0] pix_blk_t;

    // request into the inverse path
    typedef struct packed {
        qp_t       qp;
        coef_blk_t level;
        pix_blk_t  pred;
    } itq_req_t;

    // dequantized block travelling with its prediction
    typedef struct packed {
        coef_blk_t coef;
        pix_blk_t  pred;
    } deq_blk_t;

endpackage

`default_nettype wire
